// ==== logic/bus_arbiter.sv ====
`timescale 1ns/1ns

module bus_arbiter (
  input  logic              clock,
  input  logic              reset,
  input  bus_pkg::bus_req_t lsu_req,
  input  bus_pkg::bus_req_t fetch_req,
  output bus_pkg::bus_rsp_t lsu_rsp,
  output bus_pkg::bus_rsp_t fetch_rsp,
  output bus_pkg::bus_req_t mem_req,
  input  bus_pkg::bus_rsp_t mem_rsp
);

  typedef enum logic [1:0] {
    owner_none,
    owner_lsu,
    owner_fetch
  } owner_e;

  owner_e owner;
  logic   last_fetch;
  logic   outstanding;
  logic   lsu_ask, fetch_ask, done, issue;

  assign lsu_ask   = lsu_req.ar_valid || lsu_req.aw_valid;
  assign fetch_ask = fetch_req.ar_valid || fetch_req.aw_valid;
  assign done  = (mem_req.r_ready && mem_rsp.r_valid) || (mem_req.b_ready && mem_rsp.b_valid);
  assign issue = (mem_req.ar_valid && mem_rsp.ar_ready) || (mem_req.aw_valid && mem_rsp.aw_ready);

  // ##############################
  // Grant, round-robin on a tie
  always_ff @(posedge clock) begin
    if (reset) begin
      owner <= owner_none;
      last_fetch <= 1'b1;
      outstanding <= 1'b0;
    end else begin
      case (owner)
        owner_none: begin
          if (lsu_ask && (!fetch_ask || last_fetch)) begin
            owner <= owner_lsu;
            last_fetch <= 1'b0;
          end else if (fetch_ask) begin
            owner <= owner_fetch;
            last_fetch <= 1'b1;
          end
        end
        default: begin
          if (done) begin
            owner <= owner_none;
          end
        end
      endcase

      if (done) begin
        outstanding <= 1'b0;
      end else if (issue) begin
        outstanding <= 1'b1;
      end
    end
  end

  // Losing master sees every ready and valid low
  always_comb begin
    mem_req = '0;
    lsu_rsp = '0;
    fetch_rsp = '0;
    case (owner)
      owner_lsu: begin
        mem_req = lsu_req;
        lsu_rsp = mem_rsp;
      end
      owner_fetch: begin
        mem_req = fetch_req;
        fetch_rsp = mem_rsp;
      end
      default: ;
    endcase
  end

  a_owner_stable: assert property (@(posedge clock) disable iff (reset)
    (outstanding && !done) |=> $stable(owner));

endmodule

// ==== logic/bus_pkg.sv ====
package bus_pkg;

  localparam int addr_width = 32;
  localparam int data_width = 32;
  localparam int strb_width = data_width / 8;
  localparam logic [2:0] size_code_word = 3'd2;

  // Word memory behind the bus
  localparam int mem_words = 1024;
  localparam int mem_index_bits = $clog2(mem_words);

  typedef enum logic [1:0] {
    resp_okay   = 2'b00,
    resp_slverr = 2'b10
  } resp_e;

  typedef struct packed {
    logic                  ar_valid;
    logic [addr_width-1:0] ar_addr;
    logic [2:0]            ar_size;
    logic                  r_ready;
    logic                  aw_valid;
    logic [addr_width-1:0] aw_addr;
    logic [2:0]            aw_size;
    logic                  w_valid;
    logic [data_width-1:0] w_data;
    logic [strb_width-1:0] w_strb;
    logic                  b_ready;
  } bus_req_t;

  typedef struct packed {
    logic                  ar_ready;
    logic                  r_valid;
    logic [data_width-1:0] r_data;
    resp_e                 r_resp;
    logic                  aw_ready;
    logic                  w_ready;
    logic                  b_valid;
    resp_e                 b_resp;
  } bus_rsp_t;

endpackage

// ==== logic/fetch_unit.sv ====
`timescale 1ns/1ns

module fetch_unit (
  input  logic              clock,
  input  logic              reset,
  input  logic              fetch_start,
  input  logic [31:0]       fetch_pc,
  output logic              busy,
  output logic              instr_valid,
  output logic              fetch_fault,
  output logic [31:0]       instr,
  output bus_pkg::bus_req_t bus_req,
  input  bus_pkg::bus_rsp_t bus_rsp
);
  import bus_pkg::*;

  logic                  ar_valid, r_ready;
  logic [addr_width-1:0] addr_q;
  logic                  start, r_done;

  assign start  = fetch_start && !busy;
  assign r_done = r_ready && bus_rsp.r_valid;

  always_ff @(posedge clock) begin
    if (reset) begin
      busy <= 1'b0;
      ar_valid <= 1'b0;
      r_ready <= 1'b0;
      instr_valid <= 1'b0;
      fetch_fault <= 1'b0;
    end else begin
      instr_valid <= 1'b0;
      fetch_fault <= 1'b0;
      if (start) begin
        busy <= 1'b1;
        ar_valid <= 1'b1;
      end
      if (ar_valid && bus_rsp.ar_ready) begin
        ar_valid <= 1'b0;
        r_ready <= 1'b1;
      end
      if (r_done) begin
        r_ready <= 1'b0;
        busy <= 1'b0;
        instr_valid <= 1'b1;
        fetch_fault <= bus_rsp.r_resp != resp_okay;
      end
    end
  end

  // Word aligned fetch address
  always_ff @(posedge clock) begin
    if (start) begin
      addr_q <= {fetch_pc[31:2], 2'b00};
    end
    if (r_done) begin
      instr <= bus_rsp.r_data;
    end
  end

  always_comb begin
    bus_req = '0;
    bus_req.ar_valid = ar_valid;
    bus_req.ar_addr  = addr_q;
    bus_req.ar_size  = size_code_word;
    bus_req.r_ready  = r_ready;
  end

  a_no_start_busy: assert property (@(posedge clock) disable iff (reset)
    busy |-> !fetch_start);

endmodule

// ==== logic/load_store_unit.sv ====
`timescale 1ns/1ns

module load_store_unit (
  input  logic              clock,
  input  logic              reset,
  input  logic              execute_valid,
  input  lsu_pkg::lsu_cmd_t cmd,
  input  logic              clear_pipeline,
  output logic              block,
  output logic              ls_valid,
  output logic              load_misaligned,
  output logic              store_misaligned,
  output logic              bus_fault,
  output logic [31:0]       lsu_pc,
  output logic [31:0]       r_wdata,
  output bus_pkg::bus_req_t bus_req,
  input  bus_pkg::bus_rsp_t bus_rsp
);
  import bus_pkg::*;
  import lsu_pkg::*;

  lsu_cmd_t   cmd_q;
  lsu_state_e state;
  logic       squash;
  logic       ar_valid, aw_valid, w_valid, r_ready, b_ready;
  logic [31:0] req_addr, req_wdata;
  logic [2:0]  req_size;
  logic [3:0]  req_strb, strb_base;
  logic [1:0]  offset;
  logic        misaligned;
  logic [31:0] shifted, load_data;
  logic        ar_done, aw_done, w_done, r_done, b_done, resp_bad;

  assign offset = cmd_q.addr[1:0];

  always_comb begin
    case (cmd_q.size)
      size_byte: misaligned = 1'b0;
      size_half: misaligned = offset == 2'd3;
      default:   misaligned = offset != 2'd0;
    endcase
  end

  always_comb begin
    case (cmd_q.size)
      size_byte: strb_base = 4'b0001;
      size_half: strb_base = 4'b0011;
      default:   strb_base = 4'b1111;
    endcase
  end

  // Read data back down to lane zero
  assign shifted = bus_rsp.r_data >> {offset, 3'b000};

  always_comb begin
    case (cmd_q.size)
      size_byte: load_data = {{24{cmd_q.sext & shifted[7]}}, shifted[7:0]};
      size_half: load_data = {{16{cmd_q.sext & shifted[15]}}, shifted[15:0]};
      default:   load_data = shifted;
    endcase
  end

  assign ar_done = ar_valid && bus_rsp.ar_ready;
  assign aw_done = aw_valid && bus_rsp.aw_ready;
  assign w_done  = w_valid && bus_rsp.w_ready;
  assign r_done  = r_ready && bus_rsp.r_valid;
  assign b_done  = b_ready && bus_rsp.b_valid;
  assign resp_bad = r_done ? (bus_rsp.r_resp != resp_okay) : (bus_rsp.b_resp != resp_okay);

  always_ff @(posedge clock) begin
    if (!block) begin
      cmd_q <= cmd;
    end
    if (state == lsu_request) begin
      req_addr  <= cmd_q.addr;
      req_size  <= {1'b0, cmd_q.size};
      req_wdata <= cmd_q.wsrc << {offset, 3'b000};
      req_strb  <= strb_base << offset;
    end
  end

  // ##############################
  // Control
  always_ff @(posedge clock) begin
    if (reset) begin
      state <= lsu_idle;
      block <= 1'b0;
      squash <= 1'b0;
      ls_valid <= 1'b0;
      bus_fault <= 1'b0;
      load_misaligned <= 1'b0;
      store_misaligned <= 1'b0;
      ar_valid <= 1'b0;
      aw_valid <= 1'b0;
      w_valid <= 1'b0;
      r_ready <= 1'b0;
      b_ready <= 1'b0;
    end else begin
      ls_valid <= 1'b0;
      bus_fault <= 1'b0;

      if (ar_done) begin
        ar_valid <= 1'b0;
        r_ready <= 1'b1;
      end
      if (aw_done) begin
        aw_valid <= 1'b0;
      end
      if (w_done) begin
        w_valid <= 1'b0;
        b_ready <= 1'b1;
      end
      if (r_done) begin
        r_ready <= 1'b0;
      end
      if (b_done) begin
        b_ready <= 1'b0;
      end

      case (state)
        lsu_request: begin
          if (clear_pipeline) begin
            state <= lsu_idle;
          end else if (misaligned) begin
            load_misaligned <= cmd_q.ren;
            store_misaligned <= cmd_q.wen;
            block <= 1'b0;
            state <= lsu_idle;
          end else begin
            ar_valid <= cmd_q.ren;
            aw_valid <= cmd_q.wen;
            w_valid <= cmd_q.wen;
            state <= lsu_wait;
          end
        end
        lsu_wait: begin
          if (r_done || b_done) begin
            if (squash) begin
              squash <= 1'b0;
              state <= (block && !clear_pipeline) ? lsu_request : lsu_idle;
            end else begin
              ls_valid <= !clear_pipeline;
              bus_fault <= resp_bad && !clear_pipeline;
              block <= 1'b0;
              state <= lsu_idle;
              if (r_done) begin
                r_wdata <= load_data;
              end
            end
          end
        end
        default: ;
      endcase

      if (clear_pipeline) begin
        block <= 1'b0;
        load_misaligned <= 1'b0;
        store_misaligned <= 1'b0;
        // Transaction on the bus drains without a result
        if (state == lsu_wait && !(r_done || b_done)) begin
          squash <= 1'b1;
        end
      end else if (!block && execute_valid) begin
        lsu_pc <= cmd.pc;
        r_wdata <= cmd.pass_data;
        load_misaligned <= 1'b0;
        store_misaligned <= 1'b0;
        if (cmd.ren || cmd.wen) begin
          block <= 1'b1;
          if (state != lsu_wait || r_done || b_done) begin
            state <= lsu_request;
          end
        end else begin
          ls_valid <= 1'b1;
        end
      end
    end
  end

  always_comb begin
    bus_req = '0;
    bus_req.ar_valid = ar_valid;
    bus_req.ar_addr  = req_addr;
    bus_req.ar_size  = req_size;
    bus_req.r_ready  = r_ready;
    bus_req.aw_valid = aw_valid;
    bus_req.aw_addr  = req_addr;
    bus_req.aw_size  = req_size;
    bus_req.w_valid  = w_valid;
    bus_req.w_data   = req_wdata;
    bus_req.w_strb   = req_strb;
    bus_req.b_ready  = b_ready;
  end

  // Address and data channels open together and hold until a transfer
  a_aw_w_together: assert property (@(posedge clock) disable iff (reset)
    ($rose(aw_valid || w_valid) || $past(aw_valid && w_valid && !(aw_done || w_done)))
      |-> (aw_valid && w_valid));

  a_one_direction: assert property (@(posedge clock) disable iff (reset)
    !(ar_valid && aw_valid));

endmodule

// ==== logic/lsu_pkg.sv ====
package lsu_pkg;

  // Numeric value doubles as the bus size code
  typedef enum logic [1:0] {
    size_byte = 2'd0,
    size_half = 2'd1,
    size_word = 2'd2
  } access_size_e;

  typedef struct packed {
    logic         ren;
    logic         wen;
    access_size_e size;
    logic         sext;
    logic [31:0]  addr;
    logic [31:0]  wsrc;
    logic [31:0]  pc;
    logic [31:0]  pass_data;
  } lsu_cmd_t;

  typedef enum logic [1:0] {
    lsu_idle,
    lsu_request,
    lsu_wait
  } lsu_state_e;

endpackage

// ==== logic/mem_subsystem.sv ====
`timescale 1ns/1ns

module mem_subsystem (
  input  logic              clock,
  input  logic              reset,
  input  logic              execute_valid,
  input  lsu_pkg::lsu_cmd_t cmd,
  input  logic              clear_pipeline,
  output logic              block,
  output logic              ls_valid,
  output logic              load_misaligned,
  output logic              store_misaligned,
  output logic              bus_fault,
  output logic [31:0]       lsu_pc,
  output logic [31:0]       r_wdata,
  input  logic              fetch_start,
  input  logic [31:0]       fetch_pc,
  output logic              fetch_busy,
  output logic              instr_valid,
  output logic              fetch_fault,
  output logic [31:0]       instr
);
  import bus_pkg::*;

  bus_req_t lsu_req, fetch_req, mem_req;
  bus_rsp_t lsu_rsp, fetch_rsp, mem_rsp;

  // ##############################
  // Masters
  load_store_unit i_lsu (
    .clock            (clock),
    .reset            (reset),
    .execute_valid    (execute_valid),
    .cmd              (cmd),
    .clear_pipeline   (clear_pipeline),
    .block            (block),
    .ls_valid         (ls_valid),
    .load_misaligned  (load_misaligned),
    .store_misaligned (store_misaligned),
    .bus_fault        (bus_fault),
    .lsu_pc           (lsu_pc),
    .r_wdata          (r_wdata),
    .bus_req          (lsu_req),
    .bus_rsp          (lsu_rsp)
  );

  fetch_unit i_fetch (
    .clock       (clock),
    .reset       (reset),
    .fetch_start (fetch_start),
    .fetch_pc    (fetch_pc),
    .busy        (fetch_busy),
    .instr_valid (instr_valid),
    .fetch_fault (fetch_fault),
    .instr       (instr),
    .bus_req     (fetch_req),
    .bus_rsp     (fetch_rsp)
  );

  // Shared slave
  bus_arbiter i_arbiter (
    .clock     (clock),
    .reset     (reset),
    .lsu_req   (lsu_req),
    .fetch_req (fetch_req),
    .lsu_rsp   (lsu_rsp),
    .fetch_rsp (fetch_rsp),
    .mem_req   (mem_req),
    .mem_rsp   (mem_rsp)
  );

  sram_slave i_sram (
    .clock   (clock),
    .reset   (reset),
    .mem_req (mem_req),
    .mem_rsp (mem_rsp)
  );

endmodule

// ==== logic/sram_slave.sv ====
`timescale 1ns/1ns

module sram_slave (
  input  logic              clock,
  input  logic              reset,
  input  bus_pkg::bus_req_t mem_req,
  output bus_pkg::bus_rsp_t mem_rsp
);
  import bus_pkg::*;

  logic [data_width-1:0] mem [mem_words];

  logic                      r_valid, b_valid;
  logic [data_width-1:0]     r_data;
  resp_e                     r_resp, b_resp;
  logic                      ar_ready, wr_ready, ar_fire, wr_fire;
  logic                      ar_in_range, aw_in_range;
  logic [mem_index_bits-1:0] ar_index, aw_index;

  assign ar_ready = !r_valid;
  // Address and data accepted only as a pair
  assign wr_ready = mem_req.aw_valid && mem_req.w_valid && !b_valid;
  assign ar_fire  = mem_req.ar_valid && ar_ready;
  assign wr_fire  = wr_ready;

  assign ar_in_range = mem_req.ar_addr[31:2] < 30'(mem_words);
  assign aw_in_range = mem_req.aw_addr[31:2] < 30'(mem_words);
  assign ar_index = mem_req.ar_addr[mem_index_bits+1:2];
  assign aw_index = mem_req.aw_addr[mem_index_bits+1:2];

  always_ff @(posedge clock) begin
    if (wr_fire && aw_in_range) begin
      for (int i = 0; i < strb_width; i++) begin
        if (mem_req.w_strb[i]) begin
          mem[aw_index][8*i +: 8] <= mem_req.w_data[8*i +: 8];
        end
      end
    end
    if (ar_fire) begin
      r_data <= ar_in_range ? mem[ar_index] : '0;
      r_resp <= ar_in_range ? resp_okay : resp_slverr;
    end
    if (wr_fire) begin
      b_resp <= aw_in_range ? resp_okay : resp_slverr;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      r_valid <= 1'b0;
      b_valid <= 1'b0;
    end else begin
      if (ar_fire) begin
        r_valid <= 1'b1;
      end else if (mem_req.r_ready) begin
        r_valid <= 1'b0;
      end
      if (wr_fire) begin
        b_valid <= 1'b1;
      end else if (mem_req.b_ready) begin
        b_valid <= 1'b0;
      end
    end
  end

  always_comb begin
    mem_rsp = '0;
    mem_rsp.ar_ready = ar_ready;
    mem_rsp.r_valid  = r_valid;
    mem_rsp.r_data   = r_data;
    mem_rsp.r_resp   = r_resp;
    mem_rsp.aw_ready = wr_ready;
    mem_rsp.w_ready  = wr_ready;
    mem_rsp.b_valid  = b_valid;
    mem_rsp.b_resp   = b_resp;
  end

  a_read_after_addr: assert property (@(posedge clock) disable iff (reset)
    $rose(r_valid) |-> $past(ar_fire));

endmodule

// ==== mem_subsystem.f ====
logic/bus_pkg.sv
logic/lsu_pkg.sv
logic/load_store_unit.sv
logic/fetch_unit.sv
logic/bus_arbiter.sv
logic/sram_slave.sv
logic/mem_subsystem.sv
verif/mem_subsystem_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the memory subsystem testbench with Verilator
set -u
cd "$(dirname "$0")"

verilator --binary --timing --assert -sv -f mem_subsystem.f \
  --top-module mem_subsystem_tb -Mdir obj_dir -o mem_subsystem_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/mem_subsystem_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "Testbench passed"; then
  exit 0
fi
exit 1

// ==== verif/mem_subsystem_tb.sv ====
`timescale 1ns/1ns

module mem_subsystem_tb;
  import bus_pkg::*;
  import lsu_pkg::*;

  localparam int cycle_limit = 6000;
  localparam int fill_words = 64;

  typedef struct packed {
    logic [31:0] data;
    logic [31:0] pc;
    logic        fault;
    logic        check_data;
  } lsu_exp_t;

  typedef struct packed {
    logic [31:0] word;
    logic        fault;
  } fetch_exp_t;

  logic        clock, reset, execute_valid, clear_pipeline, fetch_start;
  lsu_cmd_t    cmd;
  logic [31:0] fetch_pc, lsu_pc, r_wdata, instr;
  logic        block, ls_valid, load_misaligned, store_misaligned, bus_fault;
  logic        fetch_busy, instr_valid, fetch_fault;

  logic [31:0] model [mem_words];
  lsu_exp_t    lsu_expq[$];
  fetch_exp_t  fetch_expq[$];
  logic [31:0] rand_state;
  int cycles = 0;
  int errors = 0;
  int tests = 0;
  int ops = 0;
  int test_errors_start = 0;

  mem_subsystem i_dut (.*);

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("Run stopped at cycle %0d, an operation never completed", cycles);
      $display("Testbench failed");
      $finish;
    end
  end

  function automatic logic [31:0] next_rand();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return rand_state;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp);
    errors++;
  endtask

  // ##############################
  // Reference model
  function automatic int size_bytes(access_size_e s);
    case (s)
      size_byte: return 1;
      size_half: return 2;
      default:   return 4;
    endcase
  endfunction

  // An access may not cross the word boundary
  function automatic logic misaligned_ref(access_size_e s, logic [31:0] addr);
    return int'(addr[1:0]) + size_bytes(s) > 4;
  endfunction

  function automatic logic fault_ref(logic [31:0] addr);
    return addr >= 32'(4 * mem_words);
  endfunction

  function automatic logic [31:0] load_ref(logic [31:0] word, access_size_e s, logic sext,
                                           int offset);
    logic [31:0] value;
    int          n;
    value = '0;
    n = size_bytes(s);
    for (int i = 0; i < n; i++) begin
      value[8*i +: 8] = word[8*(offset+i) +: 8];
    end
    if (sext && n < 4 && value[8*n-1]) begin
      for (int i = n; i < 4; i++) begin
        value[8*i +: 8] = 8'hff;
      end
    end
    return value;
  endfunction

  function automatic logic [31:0] store_ref(logic [31:0] word, logic [31:0] wsrc,
                                            access_size_e s, int offset);
    logic [31:0] value;
    value = word;
    for (int i = 0; i < size_bytes(s); i++) begin
      value[8*(offset+i) +: 8] = wsrc[8*i +: 8];
    end
    return value;
  endfunction

  // ##############################
  // Stimulus
  function automatic lsu_cmd_t mem_cmd(logic ren, logic wen, access_size_e size, logic sext,
                                       logic [31:0] addr, logic [31:0] wsrc);
    lsu_cmd_t c;
    c.ren = ren;
    c.wen = wen;
    c.size = size;
    c.sext = sext;
    c.addr = addr;
    c.wsrc = wsrc;
    c.pc = next_rand() & 32'hffff_fffc;
    c.pass_data = next_rand();
    return c;
  endfunction

  task automatic run_cmd(input lsu_cmd_t c);
    lsu_exp_t e;
    logic     mis;
    logic     fault;
    int       index;
    int       offset;
    mis = (c.ren || c.wen) && misaligned_ref(c.size, c.addr);
    fault = fault_ref(c.addr);
    index = int'(c.addr[mem_index_bits+1:2]);
    offset = int'(c.addr[1:0]);
    e.pc = c.pc;
    e.fault = (c.ren || c.wen) && fault;
    e.check_data = !c.wen;
    e.data = c.pass_data;
    if (c.ren) begin
      e.data = fault ? '0 : load_ref(model[index], c.size, c.sext, offset);
    end
    if (c.wen && !mis && !fault) begin
      model[index] = store_ref(model[index], c.wsrc, c.size, offset);
    end
    if (!mis) begin
      lsu_expq.push_back(e);
    end
    ops++;
    @(posedge clock);
    execute_valid <= 1'b1;
    cmd <= c;
    @(posedge clock);
    execute_valid <= 1'b0;
    @(negedge clock);
    while (!(ls_valid || load_misaligned || store_misaligned)) @(negedge clock);
    if (load_misaligned !== (mis && c.ren)) begin
      report_mismatch("load_misaligned", 32'(load_misaligned), 32'(mis && c.ren));
    end
    if (store_misaligned !== (mis && c.wen)) begin
      report_mismatch("store_misaligned", 32'(store_misaligned), 32'(mis && c.wen));
    end
  endtask

  task automatic run_fetch(input logic [31:0] pc);
    fetch_exp_t f;
    f.fault = fault_ref(pc);
    f.word = f.fault ? '0 : model[int'(pc[mem_index_bits+1:2])];
    fetch_expq.push_back(f);
    ops++;
    @(posedge clock);
    fetch_start <= 1'b1;
    fetch_pc <= pc;
    @(posedge clock);
    fetch_start <= 1'b0;
    @(negedge clock);
    if (fetch_busy !== 1'b1) report_mismatch("fetch_busy", 32'(fetch_busy), 32'd1);
    while (fetch_busy) @(negedge clock);
    if (instr_valid !== 1'b1) report_mismatch("instr_valid", 32'(instr_valid), 32'd1);
  endtask

  task automatic clear_after_cmd(input lsu_cmd_t c);
    @(posedge clock);
    execute_valid <= 1'b1;
    cmd <= c;
    @(posedge clock);
    execute_valid <= 1'b0;
    clear_pipeline <= 1'b1;
    @(posedge clock);
    clear_pipeline <= 1'b0;
    @(negedge clock);
    if (block !== 1'b0) report_mismatch("block", 32'(block), 32'd0);
    if (load_misaligned !== 1'b0) report_mismatch("load_misaligned", 32'(load_misaligned), 32'd0);
    if (store_misaligned !== 1'b0) begin
      report_mismatch("store_misaligned", 32'(store_misaligned), 32'd0);
    end
    repeat (4) @(negedge clock);
  endtask

  // Loads over all 64 words, stores kept below the fetch region
  task automatic lsu_traffic(input int n);
    logic [31:0] r;
    logic [31:0] addr;
    access_size_e size;
    for (int k = 0; k < n; k++) begin
      r = next_rand();
      size = access_size_e'(r[3:2] == 2'd3 ? 2'd2 : r[3:2]);
      addr = {24'd0, r[10:5], r[12:11]};
      if (r[1:0] == 2'd2) begin
        addr[7] = 1'b0;
        run_cmd(mem_cmd(1'b0, 1'b1, size, 1'b0, addr, next_rand()));
      end else if (r[1:0] == 2'd3) begin
        run_cmd(mem_cmd(1'b0, 1'b0, size, 1'b0, addr, next_rand()));
      end else begin
        if (r[16:13] == 4'd0) addr[12] = 1'b1;
        run_cmd(mem_cmd(1'b1, 1'b0, size, r[4], addr, '0));
      end
    end
  endtask

  task automatic fetch_traffic(input int n);
    logic [31:0] r;
    logic [31:0] pc;
    for (int k = 0; k < n; k++) begin
      r = next_rand();
      pc = {24'd0, 1'b1, r[6:0]};
      if (r[10:8] == 3'd0) pc[12] = 1'b1;
      repeat (int'(r[13:12])) @(posedge clock);
      run_fetch(pc);
    end
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("Test %0d %s: %0d errors", tests, name, errors - test_errors_start);
    test_errors_start = errors;
  endtask

  always @(negedge clock) begin : compare_results
    lsu_exp_t   e;
    fetch_exp_t f;
    if (!reset && ls_valid) begin
      if (lsu_expq.size() == 0) begin
        $display("ls_valid at %0t with no result pending", $time);
        errors++;
      end else begin
        e = lsu_expq.pop_front();
        if (e.check_data && r_wdata !== e.data) report_mismatch("r_wdata", r_wdata, e.data);
        if (lsu_pc !== e.pc) report_mismatch("lsu_pc", lsu_pc, e.pc);
        if (bus_fault !== e.fault) report_mismatch("bus_fault", 32'(bus_fault), 32'(e.fault));
      end
    end
    if (!reset && instr_valid) begin
      if (fetch_expq.size() == 0) begin
        $display("instr_valid at %0t with no fetch pending", $time);
        errors++;
      end else begin
        f = fetch_expq.pop_front();
        if (instr !== f.word) report_mismatch("instr", instr, f.word);
        if (fetch_fault !== f.fault) begin
          report_mismatch("fetch_fault", 32'(fetch_fault), 32'(f.fault));
        end
      end
    end
  end

  initial begin
    rand_state = 32'd43;
    reset = 1'b1;
    execute_valid = 1'b0;
    cmd = '0;
    clear_pipeline = 1'b0;
    fetch_start = 1'b0;
    fetch_pc = '0;
    repeat (5) @(posedge clock);
    reset <= 1'b0;

    // Fill through the LSU so SRAM and model agree
    for (int i = 0; i < fill_words; i++) begin
      run_cmd(mem_cmd(1'b0, 1'b1, size_word, 1'b0, 32'(i * 4),
                      32'(i * 4) * 32'h9e37_79b9 + 32'h0123_4567));
    end
    end_test("memory fill");

    for (int i = 0; i < 4; i++) begin
      run_cmd(mem_cmd(1'b0, 1'b1, size_byte, 1'b0, 32'(32 + i), next_rand()));
    end
    for (int i = 0; i < 3; i++) begin
      run_cmd(mem_cmd(1'b0, 1'b1, size_half, 1'b0, 32'(36 + i), next_rand()));
    end
    run_cmd(mem_cmd(1'b0, 1'b1, size_word, 1'b0, 32'h28, next_rand()));
    for (int a = 32; a < 44; a++) begin
      for (int s = 0; s < 2; s++) begin
        run_cmd(mem_cmd(1'b1, 1'b0, size_byte, s[0], 32'(a), '0));
        if (a % 4 != 3) run_cmd(mem_cmd(1'b1, 1'b0, size_half, s[0], 32'(a), '0));
        if (a % 4 == 0) run_cmd(mem_cmd(1'b1, 1'b0, size_word, s[0], 32'(a), '0));
      end
    end
    end_test("aligned stores and loads");

    for (int off = 1; off < 4; off++) begin
      run_cmd(mem_cmd(1'b0, 1'b1, size_word, 1'b0, 32'(48 + off), next_rand()));
      run_cmd(mem_cmd(1'b1, 1'b0, size_word, 1'b0, 32'(48 + off), '0));
    end
    run_cmd(mem_cmd(1'b0, 1'b1, size_half, 1'b0, 32'h37, next_rand()));
    run_cmd(mem_cmd(1'b1, 1'b0, size_half, 1'b1, 32'h37, '0));
    run_cmd(mem_cmd(1'b1, 1'b0, size_word, 1'b0, 32'h30, '0));
    run_cmd(mem_cmd(1'b1, 1'b0, size_word, 1'b0, 32'h34, '0));
    end_test("misaligned accesses");

    // Out of range addresses alias words 4 and 0 in the index bits
    run_cmd(mem_cmd(1'b0, 1'b1, size_word, 1'b0, 32'h1010, next_rand()));
    run_cmd(mem_cmd(1'b1, 1'b0, size_word, 1'b0, 32'h1010, '0));
    run_cmd(mem_cmd(1'b0, 1'b1, size_byte, 1'b0, 32'h8000_4001, next_rand()));
    run_cmd(mem_cmd(1'b1, 1'b0, size_half, 1'b1, 32'h8000_0012, '0));
    run_cmd(mem_cmd(1'b1, 1'b0, size_word, 1'b0, 32'h10, '0));
    run_cmd(mem_cmd(1'b1, 1'b0, size_byte, 1'b1, 32'h1, '0));
    end_test("out of range accesses");

    repeat (4) run_cmd(mem_cmd(1'b0, 1'b0, size_word, 1'b0, next_rand(), next_rand()));
    end_test("non-memory commands");

    fork
      lsu_traffic(150);
      fetch_traffic(60);
    join
    end_test("concurrent fetch and LSU traffic");

    clear_after_cmd(mem_cmd(1'b1, 1'b0, size_word, 1'b0, 32'h41, '0));
    clear_after_cmd(mem_cmd(1'b0, 1'b1, size_half, 1'b0, 32'h43, next_rand()));
    clear_after_cmd(mem_cmd(1'b0, 1'b1, size_word, 1'b0, 32'h40, next_rand()));
    run_cmd(mem_cmd(1'b1, 1'b0, size_word, 1'b0, 32'h40, '0));
    run_cmd(mem_cmd(1'b0, 1'b1, size_byte, 1'b0, 32'h42, next_rand()));
    run_cmd(mem_cmd(1'b1, 1'b0, size_half, 1'b1, 32'h42, '0));
    end_test("pipeline clear");

    repeat (4) @(negedge clock);
    if (lsu_expq.size() != 0 || fetch_expq.size() != 0) begin
      $display("%0d load-store and %0d fetch results never arrived",
               lsu_expq.size(), fetch_expq.size());
      errors++;
    end
    $display("Tests %0d, operations %0d, errors %0d", tests, ops, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule
